/* hw/msx_pkg.sv */
////////////////////
// MSX I/O device package
// Device bus struct, fixed I/O port numbers and the
// constants shared by the PSG tone channel
////////////////////

package msx_pkg;

    // One access on the shared device bus, valid for a single strobe cycle
    typedef struct packed {
        logic [7:0] port;
        logic [7:0] wdata;
        logic       rd;
        logic       wr;
    } dev_bus_t;

    // PPI ports
    localparam logic [7:0] PORT_PPI_SLOT   = 8'hA8;
    localparam logic [7:0] PORT_PPI_KEYS   = 8'hA9;
    localparam logic [7:0] PORT_PPI_CTRL   = 8'hAA;

    // PSG ports
    localparam logic [7:0] PORT_PSG_ADDR   = 8'hA0;
    localparam logic [7:0] PORT_PSG_WRITE  = 8'hA1;
    localparam logic [7:0] PORT_PSG_READ   = 8'hA2;

    // Tick timer ports
    localparam logic [7:0] PORT_TMR_RELOAD = 8'hE6;
    localparam logic [7:0] PORT_TMR_STATUS = 8'hE7;

    // Read data of a device that is not answering
    // Lets the top level combine all devices with a plain AND
    localparam logic [7:0] IDLE_DATA       = 8'hFF;

    // PSG register whose read returns the joystick lines
    localparam logic [3:0] PSG_JOY_REG     = 4'd14;

    // Volume to amplitude scaling of the tone channel
    localparam int         PSG_AMP_SHIFT   = 8;

endpackage

/* hw/io_bus_cycle.sv */
////////////////////
// Host bus front end
// Turns a four-phase req/ack handshake into one
// rd or wr strobe on the device bus
////////////////////

`timescale 1ns/1ns

module io_bus_cycle (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  logic              wr,
    input  logic [7:0]        port,
    input  logic [7:0]        wdata,
    output logic              ack,
    output logic [7:0]        rdata,
    output msx_pkg::dev_bus_t bus,
    input  logic [7:0]        dev_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_STROBE = 2'd1,
        ST_ACK    = 2'd2
    } state_t;

    state_t     state;
    logic [7:0] bus_port;
    logic [7:0] bus_wdata;
    logic       bus_rd;
    logic       bus_wr;

    // Sequencer and strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            bus_rd <= 1'b0;
            bus_wr <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state  <= ST_STROBE;
                        bus_rd <= ~wr;
                        bus_wr <= wr;
                    end
                end
                ST_STROBE: begin
                    state  <= ST_ACK;
                    bus_rd <= 1'b0;
                    bus_wr <= 1'b0;
                end
                ST_ACK: begin
                    // Held here as long as the host keeps req high
                    if (!req) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address and write data captured at the start of the access
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            bus_port  <= port;
            bus_wdata <= wdata;
        end
    end

    // Read data sampled during the read strobe
    always_ff @(posedge clk) begin
        if (bus_rd) begin
            rdata <= dev_rdata;
        end
    end

    assign ack = (state == ST_ACK);
    assign bus = '{port: bus_port, wdata: bus_wdata, rd: bus_rd, wr: bus_wr};

endmodule

/* hw/dev_ppi.sv */
////////////////////
// PPI device
// Slot configuration register, keyboard row
// select and key beep control
////////////////////

`timescale 1ns/1ns

module dev_ppi (
    input  logic              clk,
    input  logic              rst_n,
    input  msx_pkg::dev_bus_t bus,
    input  logic [7:0]        key_row_data,
    output logic [7:0]        data,
    output logic [7:0]        slot_config,
    output logic [3:0]        kb_row,
    output logic              keybeep
);

    // Port C image, low nibble selects the row and bit 7 drives the beep
    logic [7:0] ctrl;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_config <= 8'h00;
            ctrl        <= 8'h00;
        end else if (bus.wr) begin
            case (bus.port)
                msx_pkg::PORT_PPI_SLOT: slot_config <= bus.wdata;
                msx_pkg::PORT_PPI_CTRL: ctrl        <= bus.wdata;
                default: ;
            endcase
        end
    end

    assign kb_row  = ctrl[3:0];
    assign keybeep = ctrl[7];

    // Read mux, idle value when the port is not ours
    always_comb begin
        data = msx_pkg::IDLE_DATA;
        if (bus.rd) begin
            case (bus.port)
                msx_pkg::PORT_PPI_SLOT: data = slot_config;
                msx_pkg::PORT_PPI_KEYS: data = key_row_data;
                msx_pkg::PORT_PPI_CTRL: data = ctrl;
                default:                data = msx_pkg::IDLE_DATA;
            endcase
        end
    end

endmodule

/* hw/dev_psg.sv */
////////////////////
// PSG device
// Sixteen register file, square wave tone on
// channel A and the joystick read register
////////////////////

`timescale 1ns/1ns

module dev_psg (
    input  logic              clk,
    input  logic              rst_n,
    input  msx_pkg::dev_bus_t bus,
    input  logic [5:0]        joy,
    output logic [7:0]        data,
    output logic signed [15:0] sound
);

    logic [3:0]  reg_idx;
    logic [7:0]  regs [16];
    logic [11:0] tone_cnt;
    logic        tone_phase;
    logic [11:0] tone_period;
    logic [3:0]  volume;
    logic signed [15:0] amplitude;

    // Register index and register file
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_idx <= 4'd0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (bus.wr) begin
            if (bus.port == msx_pkg::PORT_PSG_ADDR) begin
                reg_idx <= bus.wdata[3:0];
            end else if (bus.port == msx_pkg::PORT_PSG_WRITE) begin
                regs[reg_idx] <= bus.wdata;
            end
        end
    end

    // 12 bit period from the fine and coarse tune registers
    assign tone_period = {regs[1][3:0], regs[0]};
    assign volume      = regs[8][3:0];

    // Phase flips every period plus one clocks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tone_cnt   <= 12'd0;
            tone_phase <= 1'b0;
        end else if (tone_cnt == 12'd0) begin
            tone_cnt   <= tone_period;
            tone_phase <= ~tone_phase;
        end else begin
            tone_cnt <= tone_cnt - 12'd1;
        end
    end

    assign amplitude = 16'(volume) << msx_pkg::PSG_AMP_SHIFT;

    always_comb begin
        if (volume == 4'd0) begin
            sound = 16'sd0;
        end else if (tone_phase) begin
            sound = amplitude;
        end else begin
            sound = -amplitude;
        end
    end

    // Read port, joystick register has its two top bits tied high
    always_comb begin
        data = msx_pkg::IDLE_DATA;
        if (bus.rd && bus.port == msx_pkg::PORT_PSG_READ) begin
            if (reg_idx == msx_pkg::PSG_JOY_REG) begin
                data = {2'b11, joy};
            end else begin
                data = regs[reg_idx];
            end
        end
    end

endmodule

/* hw/dev_tick_timer.sv */
////////////////////
// Periodic tick timer
// Reloadable counter that raises a pending flag
// and drives the CPU interrupt
////////////////////

`timescale 1ns/1ns

module dev_tick_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  msx_pkg::dev_bus_t bus,
    output logic [7:0]        data,
    output logic              interrupt
);

    logic [7:0] reload;
    logic [7:0] count;
    logic       enable;
    logic       pending;
    logic       status_rd;

    assign status_rd = bus.rd && (bus.port == msx_pkg::PORT_TMR_STATUS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reload  <= 8'h00;
            count   <= 8'h00;
            enable  <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (bus.wr && bus.port == msx_pkg::PORT_TMR_RELOAD) begin
                reload <= bus.wdata;
                count  <= 8'h00;
            end else if (enable) begin
                // Tick after reload plus one clocks
                if (count == reload) begin
                    count   <= 8'h00;
                    pending <= 1'b1;
                end else begin
                    count <= count + 8'h01;
                end
            end
            if (bus.wr && bus.port == msx_pkg::PORT_TMR_STATUS) begin
                enable <= bus.wdata[0];
            end
            // Status read acknowledges the tick
            if (status_rd) begin
                pending <= 1'b0;
            end
        end
    end

    always_comb begin
        data = msx_pkg::IDLE_DATA;
        if (status_rd) begin
            data = {pending, 6'b000000, enable};
        end else if (bus.rd && bus.port == msx_pkg::PORT_TMR_RELOAD) begin
            data = reload;
        end
    end

    assign interrupt = pending & enable;

endmodule

/* hw/devices.sv */
////////////////////
// I/O device block
// Bus front end with PPI, PSG and tick timer,
// read data combined by AND
////////////////////

`timescale 1ns/1ns

module devices (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  logic              wr,
    input  logic [7:0]        port,
    input  logic [7:0]        wdata,
    output logic              ack,
    output logic [7:0]        rdata,
    input  logic [7:0]        key_row_data,
    input  logic [5:0]        joy,
    output logic signed [15:0] sound,
    output logic [7:0]        slot_config,
    output logic [3:0]        kb_row,
    output logic              keybeep,
    output logic              cpu_interrupt
);

    msx_pkg::dev_bus_t bus;
    logic [7:0]        dev_rdata;
    logic [7:0]        ppi_data;
    logic [7:0]        psg_data;
    logic [7:0]        tmr_data;

    // Idle devices drive all ones
    assign dev_rdata = ppi_data & psg_data & tmr_data;

    io_bus_cycle i_bus (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .wr        (wr),
        .port      (port),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .bus       (bus),
        .dev_rdata (dev_rdata)
    );

    dev_ppi i_ppi (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus),
        .key_row_data (key_row_data),
        .data         (ppi_data),
        .slot_config  (slot_config),
        .kb_row       (kb_row),
        .keybeep      (keybeep)
    );

    dev_psg i_psg (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus),
        .joy   (joy),
        .data  (psg_data),
        .sound (sound)
    );

    dev_tick_timer i_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .data      (tmr_data),
        .interrupt (cpu_interrupt)
    );

endmodule

/* verification/devices_chk.sv */
////////////////////
// Bus front end checker
// Handshake and strobe assertions bound into io_bus_cycle
////////////////////

`timescale 1ns/1ns

module devices_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              req,
    input logic              ack,
    input msx_pkg::dev_bus_t bus
);

    // ack only rises on an edge that saw the host requesting
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(bus.rd && bus.wr))
        else $error("rd and wr strobes active together");

    rd_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) bus.rd |=> !bus.rd)
        else $error("rd strobe longer than one cycle");

    wr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) bus.wr |=> !bus.wr)
        else $error("wr strobe longer than one cycle");

    // Four-phase rule, ack holds until the host drops req
    ack_held: assert property (@(posedge clk) disable iff (!rst_n) (ack && req) |=> ack)
        else $error("ack fell while req was still high");

endmodule

bind io_bus_cycle devices_chk i_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .bus   (bus)
);

/* verification/devices_tb.sv */
////////////////////
// I/O device block testbench
// Random port traffic through the req/ack host
// interface, checked against a register model
////////////////////

`timescale 1ns/1ns

module devices_tb;

    localparam int HS_TIMEOUT = 50;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              wr;
    logic [7:0]        port;
    logic [7:0]        wdata;
    logic              ack;
    logic [7:0]        rdata;
    logic [7:0]        key_row_data;
    logic [5:0]        joy;
    logic signed [15:0] sound;
    logic [7:0]        slot_config;
    logic [3:0]        kb_row;
    logic              keybeep;
    logic              cpu_interrupt;

    integer            seed;
    int                errors;
    int                checks;
    int                tests;
    int                test_start;
    int                n;
    logic [7:0]        psg_model [16];
    logic [7:0]        slot_model;
    logic [7:0]        ctrl_model;
    logic [7:0]        reload_model;
    logic [7:0]        rd_val;
    logic [7:0]        p;
    logic [3:0]        idx;
    logic [3:0]        vol;
    logic signed [15:0] amp;
    logic signed [15:0] mag;
    logic              seen_pos;
    logic              seen_neg;
    logic              bad;

    devices i_devices (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .wr            (wr),
        .port          (port),
        .wdata         (wdata),
        .ack           (ack),
        .rdata         (rdata),
        .key_row_data  (key_row_data),
        .joy           (joy),
        .sound         (sound),
        .slot_config   (slot_config),
        .kb_row        (kb_row),
        .keybeep       (keybeep),
        .cpu_interrupt (cpu_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One four-phase handshake, returns on a falling edge with ack low
    task automatic do_access(input logic is_wr, input logic [7:0] a, input logic [7:0] d,
                             output logic [7:0] q);
        int cnt;
        @(negedge clk);
        req   = 1'b1;
        wr    = is_wr;
        port  = a;
        wdata = d;
        cnt   = 0;
        while (!ack && cnt < HS_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!ack) begin
            $display("ack did not rise for port %h within %0d cycles", a, HS_TIMEOUT);
            errors++;
        end
        q   = rdata;
        req = 1'b0;
        cnt = 0;
        while (ack && cnt < HS_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack) begin
            $display("ack did not fall for port %h within %0d cycles", a, HS_TIMEOUT);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s test finished with %0d errors", name, errors - test_start);
        tests++;
        test_start = errors;
    endtask

    function automatic logic port_is_mapped(input logic [7:0] a);
        return a inside {msx_pkg::PORT_PPI_SLOT, msx_pkg::PORT_PPI_KEYS,
                         msx_pkg::PORT_PPI_CTRL, msx_pkg::PORT_PSG_ADDR,
                         msx_pkg::PORT_PSG_WRITE, msx_pkg::PORT_PSG_READ,
                         msx_pkg::PORT_TMR_RELOAD, msx_pkg::PORT_TMR_STATUS};
    endfunction

    initial begin
        seed         = 32'h6fd2;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        test_start   = 0;
        rst_n        = 1'b0;
        req          = 1'b0;
        wr           = 1'b0;
        port         = 8'h00;
        wdata        = 8'h00;
        key_row_data = 8'hFF;
        joy          = 6'h3F;
        for (int i = 0; i < 16; i++) begin
            psg_model[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_value("ack", 16'h0, {15'h0, ack});
        check_value("slot_config", 16'h0, {8'h0, slot_config});
        check_value("kb_row", 16'h0, {12'h0, kb_row});
        check_value("keybeep", 16'h0, {15'h0, keybeep});
        check_value("cpu_interrupt", 16'h0, {15'h0, cpu_interrupt});
        check_value("sound", 16'h0, sound);
        finish_test("reset");

        for (int i = 0; i < 8; i++) begin
            slot_model = 8'($random(seed));
            ctrl_model = 8'($random(seed));
            do_access(1'b1, msx_pkg::PORT_PPI_SLOT, slot_model, rd_val);
            do_access(1'b1, msx_pkg::PORT_PPI_CTRL, ctrl_model, rd_val);
            check_value("slot_config", {8'h0, slot_model}, {8'h0, slot_config});
            check_value("kb_row", {12'h0, ctrl_model[3:0]}, {12'h0, kb_row});
            check_value("keybeep", {15'h0, ctrl_model[7]}, {15'h0, keybeep});
            do_access(1'b0, msx_pkg::PORT_PPI_SLOT, 8'h00, rd_val);
            check_value("rdata slot", {8'h0, slot_model}, {8'h0, rd_val});
            do_access(1'b0, msx_pkg::PORT_PPI_CTRL, 8'h00, rd_val);
            check_value("rdata ctrl", {8'h0, ctrl_model}, {8'h0, rd_val});
            key_row_data = 8'($random(seed));
            do_access(1'b0, msx_pkg::PORT_PPI_KEYS, 8'h00, rd_val);
            check_value("rdata keys", {8'h0, key_row_data}, {8'h0, rd_val});
        end
        finish_test("ppi");

        for (int i = 0; i < 16; i++) begin
            idx = 4'($random(seed));
            p   = 8'($random(seed));
            psg_model[idx] = p;
            do_access(1'b1, msx_pkg::PORT_PSG_ADDR, {4'h0, idx}, rd_val);
            do_access(1'b1, msx_pkg::PORT_PSG_WRITE, p, rd_val);
        end
        for (int i = 0; i < 16; i++) begin
            if (i != 14) begin
                do_access(1'b1, msx_pkg::PORT_PSG_ADDR, 8'(i), rd_val);
                do_access(1'b0, msx_pkg::PORT_PSG_READ, 8'h00, rd_val);
                check_value("rdata psg reg", {8'h0, psg_model[i]}, {8'h0, rd_val});
            end
        end
        joy = 6'($random(seed));
        do_access(1'b1, msx_pkg::PORT_PSG_ADDR, 8'd14, rd_val);
        do_access(1'b0, msx_pkg::PORT_PSG_READ, 8'h00, rd_val);
        check_value("rdata joy", {8'h0, 2'b11, joy}, {8'h0, rd_val});
        finish_test("psg");

        // Short period on channel A, then a random volume
        vol = 4'($random(seed));
        if (vol == 4'd0) begin
            vol = 4'd9;
        end
        amp = 16'(vol) << msx_pkg::PSG_AMP_SHIFT;
        do_access(1'b1, msx_pkg::PORT_PSG_ADDR, 8'd0, rd_val);
        do_access(1'b1, msx_pkg::PORT_PSG_WRITE, 8'($random(seed) & 7), rd_val);
        do_access(1'b1, msx_pkg::PORT_PSG_ADDR, 8'd1, rd_val);
        do_access(1'b1, msx_pkg::PORT_PSG_WRITE, 8'h00, rd_val);
        do_access(1'b1, msx_pkg::PORT_PSG_ADDR, 8'd8, rd_val);
        do_access(1'b1, msx_pkg::PORT_PSG_WRITE, {4'h0, vol}, rd_val);
        seen_pos = 1'b0;
        seen_neg = 1'b0;
        bad      = 1'b0;
        n        = 0;
        checks++;
        while (!(seen_pos && seen_neg) && !bad && n < 5000) begin
            @(negedge clk);
            n++;
            mag = (sound < 0) ? -sound : sound;
            if (mag !== amp) begin
                $display("mismatch sound magnitude expected %h got %h", amp, mag);
                errors++;
                bad = 1'b1;
            end
            if (sound > 0) begin
                seen_pos = 1'b1;
            end
            if (sound < 0) begin
                seen_neg = 1'b1;
            end
        end
        if (!bad && !(seen_pos && seen_neg)) begin
            $display("sound did not swing both ways within 5000 cycles");
            errors++;
        end
        do_access(1'b1, msx_pkg::PORT_PSG_WRITE, 8'h00, rd_val);
        check_value("sound", 16'h0, sound);
        finish_test("tone");

        // Reload kept above a few cycles so the flag stays clear after the read
        reload_model = 8'h10 | 8'($random(seed) & 8'h3F);
        do_access(1'b1, msx_pkg::PORT_TMR_RELOAD, reload_model, rd_val);
        do_access(1'b0, msx_pkg::PORT_TMR_RELOAD, 8'h00, rd_val);
        check_value("rdata reload", {8'h0, reload_model}, {8'h0, rd_val});
        do_access(1'b1, msx_pkg::PORT_TMR_STATUS, 8'h01, rd_val);
        n = 0;
        while (!cpu_interrupt && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_interrupt) begin
            $display("cpu_interrupt did not rise within 1000 cycles");
            errors++;
        end
        do_access(1'b0, msx_pkg::PORT_TMR_STATUS, 8'h00, rd_val);
        check_value("rdata status", 16'h0081, {8'h0, rd_val});
        check_value("cpu_interrupt", 16'h0, {15'h0, cpu_interrupt});
        do_access(1'b1, msx_pkg::PORT_TMR_STATUS, 8'h00, rd_val);
        for (int i = 0; i < 2 * (reload_model + 1) + 8; i++) begin
            @(negedge clk);
            if (cpu_interrupt) begin
                $display("cpu_interrupt rose while the timer was disabled");
                errors++;
                break;
            end
        end
        finish_test("timer");

        for (int i = 0; i < 16; i++) begin
            p = 8'($random(seed));
            if (port_is_mapped(p)) begin
                p = 8'h00;
            end
            do_access(1'b0, p, 8'h00, rd_val);
            check_value("rdata unmapped", 16'h00FF, {8'h0, rd_val});
        end
        finish_test("unmapped");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/msx_pkg.sv
hw/io_bus_cycle.sv
hw/dev_ppi.sv
hw/dev_psg.sv
hw/dev_tick_timer.sv
hw/devices.sv
verification/devices_chk.sv
verification/devices_tb.sv
